// ==== source/db_pkg.sv ====
`default_nettype none

package db_pkg;

    // ==================================================================
    // Widths
    // ==================================================================
    localparam int KEY_WIDTH   = 8;
    localparam int VALUE_WIDTH = 32;

    typedef logic [KEY_WIDTH-1:0]   key_t;
    typedef logic [VALUE_WIDTH-1:0] value_t;

    // One entry per possible key
    localparam int DEPTH = 2 ** KEY_WIDTH;

    // ==================================================================
    // Control channel encodings
    // ==================================================================
    // Codes 5 to 7 are unassigned and answered with ERROR
    typedef enum logic [2:0] {
        NOP   = 3'd0,
        GET   = 3'd1,
        SET   = 3'd2,
        UNSET = 3'd3,
        CLEAR = 3'd4
    } command_e;

    typedef enum logic {
        OK    = 1'b0,
        ERROR = 1'b1
    } status_e;

    // Command from a controller, value only matters for SET
    typedef struct packed {
        command_e command;
        key_t     key;
        value_t   value;
    } db_ctrl_req_t;

    // Found is set only by a GET hit, value is zero otherwise
    typedef struct packed {
        status_e status;
        logic    found;
        value_t  value;
    } db_ctrl_resp_t;

    // Store write payload
    typedef struct packed {
        key_t   key;
        logic   valid;
        value_t value;
    } db_wr_t;

    // Peripheral FSM
    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        CLEAR_WAIT,
        RESP
    } periph_state_e;

endpackage : db_pkg

`default_nettype wire

// ==== source/db_store_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module db_store_array (
    input  wire logic           clk,
    input  wire logic           srst,

    // Write port, takes effect on this edge
    input  wire logic           wr_en,
    input  wire db_pkg::db_wr_t wr,

    // Registered read port
    input  wire logic           rd_en,
    input  wire db_pkg::key_t   rd_key,
    output logic                rd_valid,
    output db_pkg::value_t      rd_value,

    // Clearing sweep
    input  wire logic           init,
    output logic                init_done
);

    import db_pkg::*;

    logic   sweep_active;
    key_t   sweep_key;

    logic   valid_mem [DEPTH];
    value_t value_mem [DEPTH];

    // ==================================================================
    // Sweep control
    // ==================================================================
    // One entry per cycle, DEPTH cycles in all
    always_ff @(posedge clk) begin
        if (srst) begin
            sweep_active <= 1'b1;
            sweep_key    <= '0;
        end else if (init) begin
            sweep_active <= 1'b1;
            sweep_key    <= '0;
        end else if (sweep_active) begin
            sweep_key <= sweep_key + 1'b1;
            if (sweep_key == key_t'(DEPTH - 1)) begin
                sweep_active <= 1'b0;
            end
        end
    end

    assign init_done = !sweep_active;

    // ==================================================================
    // Arrays
    // ==================================================================
    // Only the valid bits need clearing, stale values are masked by them
    always_ff @(posedge clk) begin
        if (sweep_active) begin
            valid_mem[sweep_key] <= 1'b0;
        end else if (wr_en) begin
            valid_mem[wr.key] <= wr.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            value_mem[wr.key] <= wr.value;
        end
    end

    // Read result holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_valid <= valid_mem[rd_key];
            rd_value <= value_mem[rd_key];
        end
    end

    // Peripheral must hold off all commands during a sweep
    a_no_wr_in_sweep : assert property (
        @(posedge clk) disable iff (srst)
        wr_en |-> init_done
    );

endmodule : db_store_array

`default_nettype wire

// ==== source/db_peripheral.sv ====
`timescale 1ns/1ns
`default_nettype none

module db_peripheral (
    input  wire logic                 clk,
    input  wire logic                 srst,

    // Control channel
    input  wire logic                 req,
    input  wire db_pkg::db_ctrl_req_t cmd,
    output logic                      rdy,
    output logic                      ack,
    output db_pkg::db_ctrl_resp_t     resp,

    // Store write port
    output logic                      wr_en,
    output db_pkg::db_wr_t            wr,

    // Store read port, result one cycle after rd_en
    output logic                      rd_en,
    output db_pkg::key_t              rd_key,
    input  wire logic                 rd_valid,
    input  wire db_pkg::value_t       rd_value,

    // Store clearing
    output logic                      init,
    input  wire logic                 init_done
);

    import db_pkg::*;

    periph_state_e state;
    periph_state_e state_nxt;
    db_ctrl_req_t  cmd_q;
    logic          accept;
    logic          cmd_legal;

    // ==================================================================
    // Acceptance
    // ==================================================================
    // Held off while the store sweeps
    assign rdy    = (state == IDLE) && init_done && req;
    assign accept = rdy;

    // Sweep starts on the accepting edge so init_done is already low
    // in the first CLEAR_WAIT cycle
    assign init = accept && (cmd.command == CLEAR);

    // Command latched at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

    always_comb begin
        case (cmd_q.command)
            NOP, GET, SET, UNSET, CLEAR: cmd_legal = 1'b1;
            default:                     cmd_legal = 1'b0;
        endcase
    end

    // ==================================================================
    // FSM
    // ==================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = (cmd.command == CLEAR) ? CLEAR_WAIT : EXEC;
                end
            end
            EXEC: begin
                state_nxt = RESP;
            end
            CLEAR_WAIT: begin
                if (init_done) begin
                    state_nxt = RESP;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ==================================================================
    // Store accesses
    // ==================================================================
    // Illegal codes and NOP pass through EXEC without touching the store
    assign rd_en  = (state == EXEC) && (cmd_q.command == GET);
    assign rd_key = cmd_q.key;

    assign wr_en = (state == EXEC) &&
                   ((cmd_q.command == SET) || (cmd_q.command == UNSET));

    assign wr.key   = cmd_q.key;
    assign wr.valid = (cmd_q.command == SET);
    assign wr.value = (cmd_q.command == SET) ? cmd_q.value : '0;

    // ==================================================================
    // Response
    // ==================================================================
    assign ack = (state == RESP);

    always_comb begin
        resp = '0;
        if (state == RESP) begin
            resp.status = cmd_legal ? OK : ERROR;
            // Read result registered by the store during EXEC
            if ((cmd_q.command == GET) && rd_valid) begin
                resp.found = 1'b1;
                resp.value = rd_value;
            end
        end
    end

    // A waiting controller must not change its command under us
    a_cmd_stable : assert property (
        @(posedge clk) disable iff (srst)
        (req && !rdy) |=> $stable(cmd)
    );

endmodule : db_peripheral

`default_nettype wire

// ==== source/db_ctrl_prio_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module db_ctrl_prio_mux (
    input  wire logic                  clk,
    input  wire logic                  srst,

    // High priority controller
    input  wire logic                  hi_req,
    input  wire db_pkg::db_ctrl_req_t  hi_cmd,
    output logic                       hi_rdy,
    output logic                       hi_ack,
    output db_pkg::db_ctrl_resp_t      hi_resp,

    // Low priority controller
    input  wire logic                  lo_req,
    input  wire db_pkg::db_ctrl_req_t  lo_cmd,
    output logic                       lo_rdy,
    output logic                       lo_ack,
    output db_pkg::db_ctrl_resp_t      lo_resp,

    // Merged channel towards the peripheral
    output logic                       out_req,
    output db_pkg::db_ctrl_req_t       out_cmd,
    input  wire logic                  out_rdy,
    input  wire logic                  out_ack,
    input  wire db_pkg::db_ctrl_resp_t out_resp
);

    // ==================================================================
    // Grant
    // ==================================================================
    logic granted;
    logic grant_hi;
    logic sel_hi;

    // While idle the high side wins, once locked the grant holds
    assign sel_hi = granted ? grant_hi : hi_req;

    // Lock on the first cycle a request is seen and release on the ack,
    // so a pending low side command is never swapped out under the
    // peripheral
    always_ff @(posedge clk) begin
        if (srst) begin
            granted  <= 1'b0;
            grant_hi <= 1'b0;
        end else if (granted) begin
            if (out_ack) begin
                granted <= 1'b0;
            end
        end else if (hi_req || lo_req) begin
            granted  <= 1'b1;
            grant_hi <= hi_req;
        end
    end

    // ==================================================================
    // Forward and return paths
    // ==================================================================
    assign out_req = sel_hi ? hi_req : lo_req;
    assign out_cmd = sel_hi ? hi_cmd : lo_cmd;

    // The side that is not selected sees rdy low and keeps waiting
    assign hi_rdy = out_rdy && sel_hi;
    assign lo_rdy = out_rdy && !sel_hi;

    assign hi_ack = out_ack && sel_hi;
    assign lo_ack = out_ack && !sel_hi;

    assign hi_resp = sel_hi ? out_resp : '0;
    assign lo_resp = sel_hi ? '0 : out_resp;

    // ==================================================================
    // Checks
    // ==================================================================
    // A completion only arrives while a grant is locked
    a_ack_while_granted : assert property (
        @(posedge clk) disable iff (srst)
        out_ack |-> granted
    );

    // Peripheral only accepts what was actually offered
    a_rdy_needs_req : assert property (
        @(posedge clk) disable iff (srst)
        out_rdy |-> out_req
    );

endmodule : db_ctrl_prio_mux

`default_nettype wire

// ==== source/db_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module db_top (
    input  wire logic                 clk,
    input  wire logic                 srst,

    // High priority controller
    input  wire logic                 hi_req,
    input  wire db_pkg::db_ctrl_req_t hi_cmd,
    output logic                      hi_rdy,
    output logic                      hi_ack,
    output db_pkg::db_ctrl_resp_t     hi_resp,

    // Low priority controller
    input  wire logic                 lo_req,
    input  wire db_pkg::db_ctrl_req_t lo_cmd,
    output logic                      lo_rdy,
    output logic                      lo_ack,
    output db_pkg::db_ctrl_resp_t     lo_resp,

    output logic                      init_done
);

    import db_pkg::*;

    // Merged control channel
    logic          out_req;
    db_ctrl_req_t  out_cmd;
    logic          out_rdy;
    logic          out_ack;
    db_ctrl_resp_t out_resp;

    // Store side
    logic          wr_en;
    db_wr_t        wr;
    logic          rd_en;
    key_t          rd_key;
    logic          rd_valid;
    value_t        rd_value;
    logic          init;

    // ==================================================================
    // Arbitration, execution and storage
    // ==================================================================
    db_ctrl_prio_mux i_db_ctrl_prio_mux (
        .clk      ( clk ),      .srst     ( srst ),
        .hi_req   ( hi_req ),   .hi_cmd   ( hi_cmd ),   .hi_rdy ( hi_rdy ),
        .hi_ack   ( hi_ack ),   .hi_resp  ( hi_resp ),
        .lo_req   ( lo_req ),   .lo_cmd   ( lo_cmd ),   .lo_rdy ( lo_rdy ),
        .lo_ack   ( lo_ack ),   .lo_resp  ( lo_resp ),
        .out_req  ( out_req ),  .out_cmd  ( out_cmd ),  .out_rdy ( out_rdy ),
        .out_ack  ( out_ack ),  .out_resp ( out_resp )
    );

    db_peripheral i_db_peripheral (
        .clk      ( clk ),      .srst      ( srst ),
        .req      ( out_req ),  .cmd       ( out_cmd ),   .rdy ( out_rdy ),
        .ack      ( out_ack ),  .resp      ( out_resp ),
        .wr_en    ( wr_en ),    .wr        ( wr ),
        .rd_en    ( rd_en ),    .rd_key    ( rd_key ),
        .rd_valid ( rd_valid ), .rd_value  ( rd_value ),
        .init     ( init ),     .init_done ( init_done )
    );

    db_store_array i_db_store_array (
        .clk      ( clk ),      .srst      ( srst ),
        .wr_en    ( wr_en ),    .wr        ( wr ),
        .rd_en    ( rd_en ),    .rd_key    ( rd_key ),
        .rd_valid ( rd_valid ), .rd_value  ( rd_value ),
        .init     ( init ),     .init_done ( init_done )
    );

endmodule : db_top

`default_nettype wire

// ==== test/db_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module db_tb;

    import db_pkg::*;

    localparam int          CLK_PERIOD     = 10;
    localparam int          CMDS_PER_SIDE  = 200;
    localparam int          TOTAL_CMDS     = 2 * CMDS_PER_SIDE;
    // Enough for a CLEAR sweep queued behind another command
    localparam int          CYCLES_PER_CMD = 300;
    localparam int          WATCHDOG_NS    = TOTAL_CMDS * CYCLES_PER_CMD * CLK_PERIOD;
    localparam logic [31:0] LCG_SEED       = 32'hf86f_2500;

    logic          clk = 1'b0;
    logic          srst;
    logic          hi_req;
    db_ctrl_req_t  hi_cmd;
    logic          hi_rdy;
    logic          hi_ack;
    db_ctrl_resp_t hi_resp;
    logic          lo_req;
    db_ctrl_req_t  lo_cmd;
    logic          lo_rdy;
    logic          lo_ack;
    db_ctrl_resp_t lo_resp;
    logic          init_done;

    // Reference store where a missing key is an invalid entry
    value_t model_mem [key_t];

    // Arbitration model and outstanding commands per side
    logic arb_busy    = 1'b0;
    logic arb_hi      = 1'b0;
    int   pending_hi  = 0;
    int   pending_lo  = 0;

    int   n_hits      = 0;
    int   n_misses    = 0;
    int   n_illegal   = 0;
    int   n_clears    = 0;
    int   n_contended = 0;

    db_top i_db_top (
        .clk     ( clk ),     .srst    ( srst ),
        .hi_req  ( hi_req ),  .hi_cmd  ( hi_cmd ),  .hi_rdy ( hi_rdy ),
        .hi_ack  ( hi_ack ),  .hi_resp ( hi_resp ),
        .lo_req  ( lo_req ),  .lo_cmd  ( lo_cmd ),  .lo_rdy ( lo_rdy ),
        .lo_ack  ( lo_ack ),  .lo_resp ( lo_resp ),
        .init_done ( init_done )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_resp(input db_ctrl_resp_t actual, input db_ctrl_resp_t expected,
                              input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf(
                "FAILED at %0t ns: %s, got status %0d found %0b value %h, expected %0d %0b %h",
                $time, what, actual.status, actual.found, actual.value,
                expected.status, expected.found, expected.value));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s, got %b, expected %b",
                                    $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mostly SET and GET, rare CLEAR, some illegal codes
    function automatic command_e pick_command(input logic [5:0] r);
        if (r < 24) return SET;
        else if (r < 44) return GET;
        else if (r < 52) return UNSET;
        else if (r < 55) return NOP;
        else if (r < 57) return CLEAR;
        else return command_e'(3'd5 + 3'(r % 3));
    endfunction

    // Applies a command in execution order and returns the expected answer
    function automatic db_ctrl_resp_t apply_model(input db_ctrl_req_t c);
        db_ctrl_resp_t r;
        r = '0;
        r.status = OK;
        case (c.command)
            NOP: begin
            end
            GET: begin
                if (model_mem.exists(c.key)) begin
                    r.found = 1'b1;
                    r.value = model_mem[c.key];
                    n_hits++;
                end else begin
                    n_misses++;
                end
            end
            SET: model_mem[c.key] = c.value;
            UNSET: begin
                if (model_mem.exists(c.key)) model_mem.delete(c.key);
            end
            CLEAR: begin
                model_mem.delete();
                n_clears++;
            end
            default: begin
                r.status = ERROR;
                n_illegal++;
            end
        endcase
        return r;
    endfunction

    task automatic drive_request(input logic is_hi, input logic req, input db_ctrl_req_t c);
        if (is_hi) begin
            hi_req = req;
            hi_cmd = c;
        end else begin
            lo_req = req;
            lo_cmd = c;
        end
    endtask

    // ==================================================================
    // Controllers
    // ==================================================================
    task automatic run_controller(input logic is_hi);
        logic [31:0]   lcg;
        db_ctrl_req_t  c;
        db_ctrl_resp_t expected;
        logic          saw_low;
        int            gap;
        lcg = is_hi ? LCG_SEED : ~LCG_SEED;
        for (int n = 0; n < CMDS_PER_SIDE; n++) begin
            lcg = lcg_next(lcg);
            c.command = pick_command(lcg[31:26]);
            lcg = lcg_next(lcg);
            c.key = key_t'(lcg[31:28]);
            lcg = lcg_next(lcg);
            c.value = lcg;
            lcg = lcg_next(lcg);
            gap = int'(lcg[31:30]);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            #1;
            drive_request(is_hi, 1'b1, c);
            // rdy seen here means acceptance on the next rising edge
            do @(negedge clk); while (!(is_hi ? hi_rdy : lo_rdy));
            expected = apply_model(c);
            @(posedge clk);
            #1;
            drive_request(is_hi, 1'b0, c);
            saw_low = 1'b0;
            do begin
                @(negedge clk);
                if (!init_done) saw_low = 1'b1;
            end while (!(is_hi ? hi_ack : lo_ack));
            check_resp(is_hi ? hi_resp : lo_resp, expected,
                       $sformatf("%s command %0d code %0d key %0d",
                                 is_hi ? "high" : "low", n, c.command, c.key));
            if (c.command == CLEAR) begin
                check_flag(saw_low, 1'b1, "init_done dropped during the CLEAR sweep");
                check_flag(init_done, 1'b1, "init_done high when CLEAR is acknowledged");
            end
        end
    endtask

    task automatic wait_reset_sweep();
        int cycles;
        cycles = 0;
        while (!init_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > DEPTH + 8) begin
                stop_on_error($sformatf("Error at %0t ns: init_done did not rise after reset",
                                        $time));
            end
        end
    endtask

    function automatic string coverage_gap();
        if (n_hits == 0) return "Error: no GET ever hit a stored key";
        if (n_misses == 0) return "Error: no GET ever missed";
        if (n_illegal == 0) return "Error: no illegal command code was issued";
        if (n_clears == 0) return "Error: no CLEAR was issued";
        if (n_contended == 0) return "Error: the two sides never requested together";
        return "";
    endfunction

    // ==================================================================
    // Handshake monitor
    // ==================================================================
    always @(negedge clk) begin
        if (srst) begin
            arb_busy   = 1'b0;
            pending_hi = 0;
            pending_lo = 0;
        end else begin
            if (!init_done && (hi_rdy || lo_rdy || hi_ack || lo_ack)) begin
                stop_on_error($sformatf("Error at %0t ns: rdy or ack while the store swept",
                                        $time));
            end
            // Idle multiplexer grants now with the high side first
            if (!arb_busy && (hi_req || lo_req)) begin
                arb_busy = 1'b1;
                arb_hi   = hi_req;
                if (hi_req && lo_req) n_contended++;
            end
            if (hi_rdy || lo_rdy) begin
                check_flag(hi_rdy && lo_rdy, 1'b0, "rdy on both sides");
                check_flag(hi_rdy, arb_hi, "rdy goes to the granted side");
                if (hi_rdy) pending_hi++;
                else pending_lo++;
            end
            if (hi_ack || lo_ack) begin
                check_flag(hi_ack && lo_ack, 1'b0, "ack on both sides");
                check_flag(hi_ack, arb_hi, "ack returns to the granted side");
                check_flag(hi_ack ? (pending_hi == 1) : (pending_lo == 1), 1'b1,
                           "one ack per accepted command");
                if (hi_ack) pending_hi--;
                else pending_lo--;
                arb_busy = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error($sformatf("Error at %0t ns: watchdog expired, the run hung", $time));
    end

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        string gap_msg;
        srst   = 1'b1;
        hi_req = 1'b0;
        hi_cmd = '0;
        lo_req = 1'b0;
        lo_cmd = '0;
        repeat (3) @(posedge clk);
        #1;
        srst = 1'b0;
        @(negedge clk);
        check_flag(init_done, 1'b0, "init_done low during the reset sweep");
        fork
            wait_reset_sweep();
            run_controller(1'b1);
            run_controller(1'b0);
        join
        gap_msg = coverage_gap();
        if (gap_msg != "") begin
            stop_on_error(gap_msg);
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule : db_tb

`default_nettype wire

// ==== src.f ====
source/db_pkg.sv
source/db_store_array.sv
source/db_peripheral.sv
source/db_ctrl_prio_mux.sv
source/db_top.sv
test/db_tb.sv

// ==== Makefile ====
# Verilator build and run of the key-value database testbench

TOP := db_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f src.f -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
